//--- compile.f
verilog/axi3_pkg.sv
verilog/mem_pkg.sv
verilog/sync_fifo.sv
verilog/wr_burst_builder.sv
verilog/rd_single_beat.sv
verilog/axi3_from_mem_adapter.sv
tests/axi3_mem_model.sv
tests/adapter_props.sv
tests/tb_axi3_from_mem_adapter.sv

//--- Makefile
TOP = tb_axi3_from_mem_adapter

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f compile.f -o sim

run: compile
	./obj_dir/sim | tee /dev/stderr | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir

//--- tests/tb_axi3_from_mem_adapter.sv
// Testbench for the memory to AXI3 adapter
// Directed write, burst, read-back, timeout and back-pressure tests
`default_nettype none

module tb_axi3_from_mem_adapter;
    import axi3_pkg::*;
    import mem_pkg::*;

    logic clk = 1'b0;
    logic srst;
    logic wr_req, wr_en, wr_rdy, wr_ack;
    logic [WORD_ADDR_WID-1:0] wr_addr, rd_addr;
    logic [DATA_WID-1:0] wr_data, rd_data, wdata, rdata;
    logic rd_req, rd_rdy, rd_ack;
    logic awvalid, awready, wvalid, wlast, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready;
    logic [AXI_ADDR_WID-1:0] awaddr, araddr;
    logic [AXI_LEN_WID-1:0] awlen;
    logic stall_en, stall_aw, stall_w, withhold_r;

    logic [15:0] data_st = 16'd51279;
    logic [15:0] stall_st = 16'd51279;
    int errors = 0;
    int ack_count = 0;
    int acks_expected = 0;
    logic last_wlast = 1'b0;
    logic [DATA_WID-1:0] exp_mem [logic [WORD_ADDR_WID-1:0]];

    axi3_from_mem_adapter dut_i (.*);

    axi3_mem_model mem_i (.*);

    bind wr_burst_builder adapter_props wr_props_i (
        .clk(clk), .srst(srst), .valid_a(awvalid), .ready_a(awready), .abort_a(1'b0),
        .valid_b(wvalid), .ready_b(wready), .last_b(wlast), .len_b(awlen),
        .ack(1'b0), .pending(1'b1)
    );
    bind rd_single_beat adapter_props rd_props_i (
        .clk(clk), .srst(srst), .valid_a(arvalid), .ready_a(arready),
        .abort_a(rd_timeout), .valid_b(1'b0), .ready_b(1'b0), .last_b(1'b0),
        .len_b('0), .ack(rd_ack), .pending(rd_pending)
    );

    always #2 clk = ~clk;

    // Galois LFSR, taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bits(inout logic [15:0] st, input int nbits, output logic [63:0] val);
        val = '0;
        for (int i = 0; i < nbits; i++) begin
            val = {val[62:0], st[0]};
            st = lfsr_next(st);
        end
    endtask

    // Random address and W stalls, two bits per cycle
    always @(negedge clk) begin
        logic [63:0] b;
        if (stall_en) begin
            take_bits(stall_st, 2, b);
            stall_aw = b[0];
            stall_w  = b[1];
        end else begin
            stall_aw = 1'b0;
            stall_w  = 1'b0;
        end
    end

    // W beat monitor, sampled between the edges
    always begin
        @(negedge clk);
        #1;
        if (wr_ack) begin
            ack_count++;
        end
        if (wvalid && wready) begin
            last_wlast = wlast;
        end
    end

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got == exp) else begin
            errors++;
            $display("Fail %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic send_write(input logic [15:0] a, input logic [63:0] d);
        int t;
        t = 0;
        wr_req = 1'b1;
        wr_en = 1'b1;
        wr_addr = a;
        wr_data = d;
        exp_mem[a] = d;
        #1;
        while (!wr_rdy && t < 200) begin
            @(negedge clk);
            #1;
            t++;
        end
        assert (wr_rdy) else begin
            errors++;
            $display("Write to word %h was never accepted", a);
        end
        acks_expected++;
        @(negedge clk);
    endtask

    task automatic idle_write();
        wr_req = 1'b0;
        wr_en = 1'b0;
        @(negedge clk);
    endtask

    // Wait for every write ack and for the last burst address to go out
    task automatic wait_writes(input int limit);
        int t;
        t = 0;
        #1;
        while ((ack_count != acks_expected || awvalid) && t < limit) begin
            @(negedge clk);
            #1;
            t++;
        end
        assert (ack_count == acks_expected && !awvalid) else begin
            errors++;
            $display("Timed out waiting for write acks, %0d of %0d", ack_count, acks_expected);
        end
        @(negedge clk);
    endtask

    task automatic read_word(input logic [15:0] a, input logic [63:0] exp, input int limit);
        int t;
        t = 0;
        rd_req = 1'b1;
        rd_addr = a;
        #1;
        assert (rd_rdy) else begin
            errors++;
            $display("Read port busy when reading word %h", a);
        end
        @(negedge clk);
        rd_req = 1'b0;
        #1;
        while (!rd_ack && t < limit) begin
            assert (!rd_rdy) else begin
                errors++;
                $display("rd_rdy high while the read of word %h is pending", a);
            end
            @(negedge clk);
            #1;
            t++;
        end
        assert (rd_ack) else begin
            errors++;
            $display("Timed out waiting for the read of word %h", a);
        end
        check_val("rd_data", rd_data, exp);
        @(negedge clk);
        #1;
        check_val("rd_rdy", 64'(rd_rdy), 64'd1);
        @(negedge clk);
    endtask

    // ------------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------------
    task automatic single_write_burst();
        logic [63:0] d;
        int n0;
        n0 = mem_i.len_log.size();
        take_bits(data_st, 64, d);
        send_write(16'h0005, d);
        idle_write();
        wait_writes(200);
        check_val("burst count", 64'(mem_i.len_log.size()), 64'(n0 + 1));
        check_val("awaddr", 64'(mem_i.addr_log[n0]), 64'(BASE_ADDR + 32'd40));
        check_val("awlen", 64'(mem_i.len_log[n0]), 64'd0);
        check_val("wlast", 64'(last_wlast), 64'd1);
        check_val("stored data", mem_i.mem[BASE_ADDR + 32'd40], d);
    endtask

    task automatic long_run_bursts();
        logic [63:0] d;
        int n0;
        int a0;
        n0 = mem_i.len_log.size();
        a0 = ack_count;
        for (int i = 0; i < 20; i++) begin
            take_bits(data_st, 64, d);
            send_write(16'(100 + i), d);
        end
        idle_write();
        wait_writes(400);
        check_val("burst count", 64'(mem_i.len_log.size()), 64'(n0 + 2));
        check_val("awlen", 64'(mem_i.len_log[n0]), 64'd15);
        check_val("awlen", 64'(mem_i.len_log[n0 + 1]), 64'd3);
        check_val("wr_ack count", 64'(ack_count - a0), 64'd20);
    endtask

    task automatic address_gap_bursts();
        logic [63:0] d;
        int n0;
        n0 = mem_i.len_log.size();
        take_bits(data_st, 64, d);
        send_write(16'd10, d);
        take_bits(data_st, 64, d);
        send_write(16'd11, d);
        take_bits(data_st, 64, d);
        send_write(16'd30, d);
        idle_write();
        wait_writes(200);
        check_val("burst count", 64'(mem_i.len_log.size()), 64'(n0 + 2));
        check_val("awaddr", 64'(mem_i.addr_log[n0]), 64'(BASE_ADDR + 32'd80));
        check_val("awlen", 64'(mem_i.len_log[n0]), 64'd1);
        check_val("awaddr", 64'(mem_i.addr_log[n0 + 1]), 64'(BASE_ADDR + 32'd240));
        check_val("awlen", 64'(mem_i.len_log[n0 + 1]), 64'd0);
    endtask

    task automatic read_back_words();
        read_word(16'd5, exp_mem[16'd5], RD_TIMEOUT + 4);
        for (int i = 100; i < 120; i++) begin
            read_word(16'(i), exp_mem[16'(i)], RD_TIMEOUT + 4);
        end
        read_word(16'd10, exp_mem[16'd10], RD_TIMEOUT + 4);
        read_word(16'd11, exp_mem[16'd11], RD_TIMEOUT + 4);
        read_word(16'd30, exp_mem[16'd30], RD_TIMEOUT + 4);
    endtask

    task automatic read_timeout_zero();
        withhold_r = 1'b1;
        read_word(16'd5, 64'd0, RD_TIMEOUT + 4);
        withhold_r = 1'b0;
    endtask

    task automatic back_pressure_writes();
        logic [63:0] v;
        logic [63:0] d;
        logic [15:0] addrs [$];
        int a0;
        a0 = ack_count;
        stall_en = 1'b1;
        for (int i = 0; i < 100; i++) begin
            take_bits(data_st, 8, v);
            take_bits(data_st, 64, d);
            addrs.push_back(16'h0400 + 16'(v[7:0]));
            send_write(addrs[i], d);
        end
        idle_write();
        wait_writes(4000);
        check_val("wr_ack count", 64'(ack_count - a0), 64'd100);
        foreach (addrs[i]) begin
            read_word(addrs[i], exp_mem[addrs[i]], RD_TIMEOUT + 4);
        end
        stall_en = 1'b0;
    endtask

    initial begin
        srst = 1'b1;
        wr_req = 1'b0;
        wr_en = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        rd_req = 1'b0;
        rd_addr = '0;
        stall_en = 1'b0;
        stall_aw = 1'b0;
        stall_w = 1'b0;
        withhold_r = 1'b0;
        repeat (8) @(negedge clk);
        srst = 1'b0;
        #1;
        check_val("wr_rdy", 64'(wr_rdy), 64'd1);
        check_val("rd_rdy", 64'(rd_rdy), 64'd1);
        check_val("bready", 64'(bready), 64'd1);
        check_val("valids", 64'({awvalid, wvalid, arvalid, rready, rd_ack, wr_ack}), 64'd0);
        @(negedge clk);
        single_write_burst();
        long_run_bursts();
        address_gap_bursts();
        read_back_words();
        read_timeout_zero();
        back_pressure_writes();
        $display("Tests done, errors: %0d, write acks: %0d", errors, ack_count);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule : tb_axi3_from_mem_adapter

`default_nettype wire

//--- tests/adapter_props.sv
// Handshake properties for the adapter write and read paths
// Valid holds until ready, wlast on beat awlen, no ack without a pending read
`default_nettype none

module adapter_props (
    input  logic                             clk,
    input  logic                             srst,
    input  logic                             valid_a,
    input  logic                             ready_a,
    input  logic                             abort_a,
    input  logic                             valid_b,
    input  logic                             ready_b,
    input  logic                             last_b,
    input  logic [axi3_pkg::AXI_LEN_WID-1:0] len_b,
    input  logic                             ack,
    input  logic                             pending
);
    import axi3_pkg::*;

    logic [AXI_LEN_WID-1:0] beat_cnt;

    // Own beat count within the current burst
    always_ff @(posedge clk) begin
        if (srst) begin
            beat_cnt <= '0;
        end else if (valid_b && ready_b) begin
            beat_cnt <= last_b ? '0 : beat_cnt + 1'b1;
        end
    end

    addr_valid_held: assert property (@(posedge clk) disable iff (srst)
        valid_a && !ready_a && !abort_a |=> valid_a)
        else $error("Address valid dropped before ready");

    data_valid_held: assert property (@(posedge clk) disable iff (srst)
        valid_b && !ready_b |=> valid_b)
        else $error("Data valid dropped before ready");

    last_on_final_beat: assert property (@(posedge clk) disable iff (srst)
        valid_b |-> (last_b == (beat_cnt == len_b)))
        else $error("wlast not on beat awlen");

    ack_needs_pending: assert property (@(posedge clk) disable iff (srst)
        ack |-> pending)
        else $error("Read ack without a pending read");

endmodule : adapter_props

`default_nettype wire

//--- tests/axi3_mem_model.sv
// AXI3 subordinate memory model for the adapter testbench
// Stores beats by byte address, logs each burst, optional address/W stalls and R withholding
`default_nettype none

module axi3_mem_model (
    input  logic                              clk,
    input  logic                              srst,
    input  logic                              awvalid,
    input  logic [axi3_pkg::AXI_ADDR_WID-1:0] awaddr,
    input  logic [axi3_pkg::AXI_LEN_WID-1:0]  awlen,
    output logic                              awready,
    input  logic                              wvalid,
    input  logic [axi3_pkg::DATA_WID-1:0]     wdata,
    output logic                              wready,
    output logic                              bvalid,
    input  logic                              arvalid,
    input  logic [axi3_pkg::AXI_ADDR_WID-1:0] araddr,
    output logic                              arready,
    output logic                              rvalid,
    output logic [axi3_pkg::DATA_WID-1:0]     rdata,
    input  logic                              rready,
    input  logic                              stall_aw,
    input  logic                              stall_w,
    input  logic                              withhold_r
);
    import axi3_pkg::*;

    logic [DATA_WID-1:0]     mem [logic [AXI_ADDR_WID-1:0]];
    logic [AXI_LEN_WID-1:0]  len_log [$];
    logic [AXI_ADDR_WID-1:0] addr_log [$];
    logic [AXI_ADDR_WID-1:0] aw_q [$];
    logic [AXI_LEN_WID-1:0]  awlen_q [$];
    logic [DATA_WID-1:0]     w_q [$];

    // Both address channels share one stall bit
    assign awready = !stall_aw;
    assign wready  = !stall_w;
    assign arready = !stall_aw;

    // Beats may arrive before their address, so both sides queue up
    always @(posedge clk) begin
        bvalid <= 1'b0;
        if (!srst) begin
            if (awvalid && awready) begin
                aw_q.push_back(awaddr);
                awlen_q.push_back(awlen);
                addr_log.push_back(awaddr);
                len_log.push_back(awlen);
            end
            if (wvalid && wready) begin
                w_q.push_back(wdata);
            end
            while (aw_q.size() > 0 && w_q.size() > int'(awlen_q[0])) begin
                for (int i = 0; i <= int'(awlen_q[0]); i++) begin
                    mem[aw_q[0] + AXI_ADDR_WID'(i * DATA_BYTES)] = w_q.pop_front();
                end
                void'(aw_q.pop_front());
                void'(awlen_q.pop_front());
                bvalid <= 1'b1;
            end
        end
    end

    // Single-beat reads, one cycle after the address
    always @(posedge clk) begin
        if (srst) begin
            rvalid <= 1'b0;
            rdata  <= '0;
        end else begin
            if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
            if (arvalid && arready && !withhold_r) begin
                rvalid <= 1'b1;
                rdata  <= mem.exists(araddr) ? mem[araddr] : '0;
            end
        end
    end

endmodule : axi3_mem_model

`default_nettype wire

//--- verilog/axi3_from_mem_adapter.sv
// Memory request port to AXI3 manager adapter, top level
// Write burst builder and single-beat read path side by side
`default_nettype none

module axi3_from_mem_adapter (
    input  logic                              clk,
    input  logic                              srst,

    // Memory write port
    input  logic                              wr_req,
    input  logic                              wr_en,
    input  logic [mem_pkg::WORD_ADDR_WID-1:0] wr_addr,
    input  logic [axi3_pkg::DATA_WID-1:0]     wr_data,
    output logic                              wr_rdy,
    output logic                              wr_ack,

    // Memory read port
    input  logic                              rd_req,
    input  logic [mem_pkg::WORD_ADDR_WID-1:0] rd_addr,
    output logic                              rd_rdy,
    output logic                              rd_ack,
    output logic [axi3_pkg::DATA_WID-1:0]     rd_data,

    // AXI3 write channels
    output logic                              awvalid,
    output logic [axi3_pkg::AXI_ADDR_WID-1:0] awaddr,
    output logic [axi3_pkg::AXI_LEN_WID-1:0]  awlen,
    input  logic                              awready,
    output logic                              wvalid,
    output logic [axi3_pkg::DATA_WID-1:0]     wdata,
    output logic                              wlast,
    input  logic                              wready,
    input  logic                              bvalid,
    output logic                              bready,

    // AXI3 read channels
    output logic                              arvalid,
    output logic [axi3_pkg::AXI_ADDR_WID-1:0] araddr,
    input  logic                              arready,
    input  logic                              rvalid,
    input  logic [axi3_pkg::DATA_WID-1:0]     rdata,
    output logic                              rready
);

    wr_burst_builder wr_i (
        .clk     (clk),
        .srst    (srst),
        .wr_req  (wr_req),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .wr_rdy  (wr_rdy),
        .wr_ack  (wr_ack),
        .awvalid (awvalid),
        .awaddr  (awaddr),
        .awlen   (awlen),
        .awready (awready),
        .wvalid  (wvalid),
        .wdata   (wdata),
        .wlast   (wlast),
        .wready  (wready),
        .bvalid  (bvalid),
        .bready  (bready)
    );

    rd_single_beat rd_i (
        .clk     (clk),
        .srst    (srst),
        .rd_req  (rd_req),
        .rd_addr (rd_addr),
        .rd_rdy  (rd_rdy),
        .rd_ack  (rd_ack),
        .rd_data (rd_data),
        .arvalid (arvalid),
        .araddr  (araddr),
        .arready (arready),
        .rvalid  (rvalid),
        .rdata   (rdata),
        .rready  (rready)
    );

endmodule : axi3_from_mem_adapter

`default_nettype wire

//--- verilog/rd_single_beat.sv
// Read path of the memory to AXI3 adapter
// One outstanding single-beat read with a response timeout
`default_nettype none

module rd_single_beat (
    input  logic                              clk,
    input  logic                              srst,
    input  logic                              rd_req,
    input  logic [mem_pkg::WORD_ADDR_WID-1:0] rd_addr,
    output logic                              rd_rdy,
    output logic                              rd_ack,
    output logic [axi3_pkg::DATA_WID-1:0]     rd_data,
    output logic                              arvalid,
    output logic [axi3_pkg::AXI_ADDR_WID-1:0] araddr,
    input  logic                              arready,
    input  logic                              rvalid,
    input  logic [axi3_pkg::DATA_WID-1:0]     rdata,
    output logic                              rready
);
    import axi3_pkg::*;
    import mem_pkg::*;

    localparam int RD_TIMER_WID = $clog2(RD_TIMEOUT);

    logic                    rd_accept;
    logic                    rd_pending;
    logic                    r_fire;
    logic                    rd_timeout;
    logic [RD_TIMER_WID-1:0] rd_timer;

    assign rd_rdy    = !rd_pending;
    assign rd_accept = rd_req && rd_rdy;
    assign r_fire    = rvalid && rready;

    // ------------------------------------------------------------------------
    // Request
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            rd_pending <= 1'b0;
            arvalid    <= 1'b0;
        end else begin
            if (rd_accept) begin
                rd_pending <= 1'b1;
            end else if (rd_ack) begin
                rd_pending <= 1'b0;
            end
            if (rd_accept) begin
                arvalid <= 1'b1;
            end else if (arready || rd_timeout) begin
                arvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_accept) begin
            araddr <= BASE_ADDR + (AXI_ADDR_WID'(rd_addr) << BYTE_SEL_WID);
        end
    end

    // ------------------------------------------------------------------------
    // Timeout
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            rd_timer <= '0;
        end else if (rd_pending) begin
            rd_timer <= rd_timer + 1'b1;
        end else begin
            rd_timer <= '0;
        end
    end

    // Only while still waiting for R; a beat in the last cycle wins
    assign rd_timeout = rready && rd_pending && !rvalid &&
                        (rd_timer == RD_TIMER_WID'(RD_TIMEOUT - 1));

    // ------------------------------------------------------------------------
    // Response
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            rready <= 1'b0;
            rd_ack <= 1'b0;
        end else begin
            if (rd_accept) begin
                rready <= 1'b1;
            end else if (rd_pending) begin
                if (r_fire || rd_timeout) begin
                    rready <= 1'b0;
                end
            end else begin
                // Drain a late beat left over from a timed-out read
                rready <= rvalid;
            end
            rd_ack <= rd_timeout || (r_fire && rd_pending);
        end
    end

    always_ff @(posedge clk) begin
        if (r_fire && rd_pending) begin
            rd_data <= rdata;
        end else if (rd_timeout) begin
            rd_data <= '0;
        end
    end

endmodule : rd_single_beat

`default_nettype wire

//--- verilog/wr_burst_builder.sv
// Write path of the memory to AXI3 adapter
// Groups consecutive word writes into INCR bursts and drives AW, W and B
`default_nettype none

module wr_burst_builder (
    input  logic                             clk,
    input  logic                             srst,
    input  logic                             wr_req,
    input  logic                             wr_en,
    input  logic [mem_pkg::WORD_ADDR_WID-1:0] wr_addr,
    input  logic [axi3_pkg::DATA_WID-1:0]    wr_data,
    output logic                             wr_rdy,
    output logic                             wr_ack,
    output logic                             awvalid,
    output logic [axi3_pkg::AXI_ADDR_WID-1:0] awaddr,
    output logic [axi3_pkg::AXI_LEN_WID-1:0] awlen,
    input  logic                             awready,
    output logic                             wvalid,
    output logic [axi3_pkg::DATA_WID-1:0]    wdata,
    output logic                             wlast,
    input  logic                             wready,
    input  logic                             bvalid,
    output logic                             bready
);
    import axi3_pkg::*;
    import mem_pkg::*;

    wr_state_t                wr_state;
    wr_state_t                nxt_wr_state;
    logic                     wr_accept;
    logic                     burst_reset;
    logic                     burst_inc;
    logic                     burst_done;
    logic [WORD_ADDR_WID-1:0] burst_addr;
    logic [WORD_ADDR_WID-1:0] burst_addr_nxt;
    logic [AXI_LEN_WID-1:0]   burst_len;

    logic                     data_vld;
    logic                     ctxt_vld;
    logic [WORD_ADDR_WID-1:0] ctxt_addr;
    logic [AXI_LEN_WID-1:0]   ctxt_len;

    logic                     aw_fire;
    logic                     w_fire;
    logic                     w_last_fire;
    logic                     aw_done;
    logic                     w_done;
    logic                     sop;
    logic [AXI_LEN_WID-1:0]   beat_cnt;
    logic                     burst_retire;

    // ------------------------------------------------------------------------
    // Write data buffer
    // ------------------------------------------------------------------------
    sync_fifo #(
        .WIDTH (DATA_WID),
        .DEPTH (MAX_BURST_LEN)
    ) data_fifo_i (
        .clk     (clk),
        .srst    (srst),
        .wr      (wr_req && wr_en),
        .wr_rdy  (wr_rdy),
        .wr_data (wr_data),
        .rd      (w_fire),
        .rd_vld  (data_vld),
        .rd_data (wdata)
    );

    assign wr_accept = wr_req && wr_en && wr_rdy;

    // ------------------------------------------------------------------------
    // Burst grouping FSM
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            wr_state <= RESET;
        end else begin
            wr_state <= nxt_wr_state;
        end
    end

    always_comb begin
        nxt_wr_state = wr_state;
        burst_reset  = 1'b0;
        burst_inc    = 1'b0;
        burst_done   = 1'b0;
        case (wr_state)
            RESET, BURST_START: begin
                burst_reset = 1'b1;
                if (wr_accept) begin
                    nxt_wr_state = BURST;
                end else begin
                    nxt_wr_state = BURST_START;
                end
            end
            BURST: begin
                if (wr_accept) begin
                    // Extend on the next word, else close and open a new one
                    if (wr_addr == burst_addr_nxt &&
                        burst_len < AXI_LEN_WID'(MAX_BURST_LEN - 1)) begin
                        burst_inc = 1'b1;
                    end else begin
                        burst_done = 1'b1;
                    end
                end else begin
                    // Idle cycle closes the open burst
                    burst_done   = 1'b1;
                    nxt_wr_state = BURST_START;
                end
            end
            default: begin
                nxt_wr_state = RESET;
            end
        endcase
    end

    // Open burst start, next expected word and length minus one
    always_ff @(posedge clk) begin
        if (burst_reset || burst_done) begin
            burst_addr     <= wr_addr;
            burst_addr_nxt <= wr_addr + 1'b1;
            burst_len      <= '0;
        end else if (burst_inc) begin
            burst_addr_nxt <= burst_addr_nxt + 1'b1;
            burst_len      <= burst_len + 1'b1;
        end
    end

    // Closed bursts wait here; the head is held until both AW and W finish
    sync_fifo #(
        .WIDTH (WORD_ADDR_WID + AXI_LEN_WID),
        .DEPTH (BURST_CTXT_DEPTH)
    ) ctxt_fifo_i (
        .clk     (clk),
        .srst    (srst),
        .wr      (burst_done),
        .wr_rdy  (),
        .wr_data ({burst_addr, burst_len}),
        .rd      (burst_retire),
        .rd_vld  (ctxt_vld),
        .rd_data ({ctxt_addr, ctxt_len})
    );

    // ------------------------------------------------------------------------
    // AW and W channels
    // ------------------------------------------------------------------------
    // AW rises together with the first beat and then holds until accepted
    assign awvalid = ctxt_vld && !aw_done && (data_vld || !sop || w_done);
    assign awaddr  = BASE_ADDR + (AXI_ADDR_WID'(ctxt_addr) << BYTE_SEL_WID);
    assign awlen   = ctxt_len;

    // Beats of the next burst wait until this one is retired
    assign wvalid = ctxt_vld && !w_done && data_vld;
    assign wlast  = (beat_cnt == ctxt_len);

    assign aw_fire      = awvalid && awready;
    assign w_fire       = wvalid && wready;
    assign w_last_fire  = w_fire && wlast;
    assign burst_retire = (aw_done || aw_fire) && (w_done || w_last_fire);

    always_ff @(posedge clk) begin
        if (srst) begin
            aw_done  <= 1'b0;
            w_done   <= 1'b0;
            sop      <= 1'b1;
            beat_cnt <= '0;
        end else begin
            if (burst_retire) begin
                aw_done <= 1'b0;
                w_done  <= 1'b0;
            end else begin
                if (aw_fire) begin
                    aw_done <= 1'b1;
                end
                if (w_last_fire) begin
                    w_done <= 1'b1;
                end
            end
            if (w_last_fire) begin
                beat_cnt <= '0;
                sop      <= 1'b1;
            end else if (w_fire) begin
                beat_cnt <= beat_cnt + 1'b1;
                sop      <= 1'b0;
            end
        end
    end

    // Each beat is acknowledged as it crosses W
    assign wr_ack = w_fire;

    // Responses are always taken; bvalid and its code carry no state here
    assign bready = 1'b1;

endmodule : wr_burst_builder

`default_nettype wire

//--- verilog/sync_fifo.sv
// Synchronous first-word-fall-through FIFO
// Circular buffer with an occupancy count, full and valid flags
`default_nettype none

module sync_fifo #(
    parameter int WIDTH = axi3_pkg::DATA_WID,
    parameter int DEPTH = mem_pkg::MAX_BURST_LEN
) (
    input  logic             clk,
    input  logic             srst,
    input  logic             wr,
    output logic             wr_rdy,
    input  logic [WIDTH-1:0] wr_data,
    input  logic             rd,
    output logic             rd_vld,
    output logic [WIDTH-1:0] rd_data
);

    localparam int PTR_WID = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_WID = $clog2(DEPTH + 1);

    logic [WIDTH-1:0]   mem [DEPTH];
    logic [PTR_WID-1:0] wr_ptr;
    logic [PTR_WID-1:0] rd_ptr;
    logic [CNT_WID-1:0] count;
    logic               push;
    logic               pop;

    // Pointer advance with wrap at DEPTH
    function automatic logic [PTR_WID-1:0] ptr_inc(input logic [PTR_WID-1:0] ptr);
        if (ptr == PTR_WID'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign wr_rdy = (count < CNT_WID'(DEPTH));
    assign rd_vld = (count != '0);
    assign push   = wr && wr_rdy;
    assign pop    = rd && rd_vld;

    // Head word is always presented
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (srst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule : sync_fifo

`default_nettype wire

//--- verilog/mem_pkg.sv
// Memory request port constants
// Word address width, burst limits, read timeout and write-burst FSM states
`default_nettype none

package mem_pkg;

    localparam int WORD_ADDR_WID = 16;

    // Longest INCR burst built from consecutive writes
    localparam int MAX_BURST_LEN = 16;

    // Bursts closed but not yet issued on AW
    localparam int BURST_CTXT_DEPTH = 32;

    // Cycles a read waits for its R beat
    localparam int RD_TIMEOUT = 64;

    // Write-burst grouping FSM
    typedef enum logic [1:0] {
        RESET,
        BURST_START,
        BURST
    } wr_state_t;

endpackage : mem_pkg

`default_nettype wire

//--- verilog/axi3_pkg.sv
// AXI3 manager-side constants
// Transfer-size encoding, data width, address and burst-length widths
`default_nettype none

package axi3_pkg;

    // AxSIZE encoding, bytes per beat
    typedef enum logic [2:0] {
        SIZE_1BYTE    = 3'd0,
        SIZE_2BYTES   = 3'd1,
        SIZE_4BYTES   = 3'd2,
        SIZE_8BYTES   = 3'd3,
        SIZE_16BYTES  = 3'd4,
        SIZE_32BYTES  = 3'd5,
        SIZE_64BYTES  = 3'd6,
        SIZE_128BYTES = 3'd7
    } axsize_t;

    // Full 8-byte beats on the peripheral side
    localparam axsize_t SIZE = SIZE_8BYTES;

    localparam int DATA_BYTES   = 2 ** int'(SIZE);
    localparam int DATA_WID     = DATA_BYTES * 8;
    // Word to byte address shift
    localparam int BYTE_SEL_WID = $clog2(DATA_BYTES);

    localparam int AXI_ADDR_WID = 32;
    localparam int AXI_LEN_WID  = 4;

    // Byte base of the peripheral window, a power of two
    localparam logic [AXI_ADDR_WID-1:0] BASE_ADDR = 32'h1000_0000;

endpackage : axi3_pkg

`default_nettype wire
